// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - hdl/mipsIsaPkg.sv
  - hdl/mipsCtrlPkg.sv
  - hdl/fetchUnit.sv
  - hdl/controlDecoder.sv
  - hdl/registerFile.sv
  - hdl/executeUnit.sv
  - hdl/memoryStage.sv
  - hdl/mipsCore.sv
  - target: test
    files:
      - testbench/mipsCoreChecker.sv
      - testbench/mipsCore_asserts.sv
      - testbench/mipsCoreTb.sv

// ==== hdl/controlDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
	input  wire mipsIsaPkg::wordT instr,
	output mipsCtrlPkg::aluOpT aluOp,
	output mipsCtrlPkg::aluBSelT aluBSel,
	output mipsCtrlPkg::extendSignT extendSign,
	output mipsCtrlPkg::branchKindT branchKind,
	output mipsCtrlPkg::jumpKindT jumpKind,
	output mipsCtrlPkg::wbSelT wbSel,
	output logic memWrite,
	output logic regWrite,
	output mipsIsaPkg::regAddrT writeAddr
);

	logic [mipsIsaPkg::opcodeWidth-1:0] opcode;
	logic [mipsIsaPkg::functWidth-1:0] funct;
	mipsIsaPkg::regAddrT rt;
	mipsIsaPkg::regAddrT rd;

	assign opcode = instr[mipsIsaPkg::opLsb +: mipsIsaPkg::opcodeWidth];
	assign funct = instr[mipsIsaPkg::functWidth-1:0];
	assign rt = instr[mipsIsaPkg::rtLsb +: mipsIsaPkg::regAddrWidth];
	assign rd = instr[mipsIsaPkg::rdLsb +: mipsIsaPkg::regAddrWidth];

	always_comb begin
		aluOp = mipsCtrlPkg::aluAdd;
		aluBSel = mipsCtrlPkg::bSelRt;
		extendSign = mipsCtrlPkg::extZero;
		branchKind = mipsCtrlPkg::branchNone;
		jumpKind = mipsCtrlPkg::jumpNone;
		wbSel = mipsCtrlPkg::wbAlu;
		memWrite = 1'b0;
		regWrite = 1'b0;
		writeAddr = rt; // Immediates and loads

		case (opcode)
			mipsIsaPkg::opSpecial: begin
				writeAddr = rd;
				regWrite = 1'b1; // All-zero word lands here and writes r0
				case (funct)
					mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu: aluOp = mipsCtrlPkg::aluAdd;
					mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: aluOp = mipsCtrlPkg::aluSub;
					mipsIsaPkg::fnAnd: aluOp = mipsCtrlPkg::aluAnd;
					mipsIsaPkg::fnOr: aluOp = mipsCtrlPkg::aluOr;
					mipsIsaPkg::fnXor: aluOp = mipsCtrlPkg::aluXor;
					mipsIsaPkg::fnNor: aluOp = mipsCtrlPkg::aluNor;
					mipsIsaPkg::fnSlt: aluOp = mipsCtrlPkg::aluSlt;
					mipsIsaPkg::fnSll: begin
						aluOp = mipsCtrlPkg::aluSll;
						aluBSel = mipsCtrlPkg::bSelShamt;
					end
					mipsIsaPkg::fnSrl: begin
						aluOp = mipsCtrlPkg::aluSrl;
						aluBSel = mipsCtrlPkg::bSelShamt;
					end
					mipsIsaPkg::fnJr: begin
						regWrite = 1'b0;
						jumpKind = mipsCtrlPkg::jumpRegister;
					end
					default: regWrite = 1'b0;
				endcase
			end
			mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: begin
				aluBSel = mipsCtrlPkg::bSelImm;
				extendSign = mipsCtrlPkg::extSign;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opSlti: begin
				aluOp = mipsCtrlPkg::aluSlt;
				aluBSel = mipsCtrlPkg::bSelImm;
				extendSign = mipsCtrlPkg::extSign;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opAndi: begin
				aluOp = mipsCtrlPkg::aluAnd;
				aluBSel = mipsCtrlPkg::bSelImm;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opOri: begin
				aluOp = mipsCtrlPkg::aluOr;
				aluBSel = mipsCtrlPkg::bSelImm;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opXori: begin
				aluOp = mipsCtrlPkg::aluXor;
				aluBSel = mipsCtrlPkg::bSelImm;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opLui: begin
				aluOp = mipsCtrlPkg::aluLui;
				aluBSel = mipsCtrlPkg::bSelImm;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opLw: begin
				aluBSel = mipsCtrlPkg::bSelImm;
				extendSign = mipsCtrlPkg::extSign;
				wbSel = mipsCtrlPkg::wbMem;
				regWrite = 1'b1;
			end
			mipsIsaPkg::opSw: begin
				aluBSel = mipsCtrlPkg::bSelImm;
				extendSign = mipsCtrlPkg::extSign;
				memWrite = 1'b1;
			end
			mipsIsaPkg::opBeq: begin
				aluOp = mipsCtrlPkg::aluSub;
				branchKind = mipsCtrlPkg::branchEq;
			end
			mipsIsaPkg::opBne: begin
				aluOp = mipsCtrlPkg::aluSub;
				branchKind = mipsCtrlPkg::branchNe;
			end
			mipsIsaPkg::opJ: jumpKind = mipsCtrlPkg::jumpAbsolute;
			mipsIsaPkg::opJal: begin
				jumpKind = mipsCtrlPkg::jumpAbsolute;
				wbSel = mipsCtrlPkg::wbLink; // Return address is pc+4
				writeAddr = mipsIsaPkg::linkReg;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/executeUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
	input  wire mipsIsaPkg::wordT instr,
	input  wire mipsIsaPkg::wordT readData1,
	input  wire mipsIsaPkg::wordT readData2,
	input  wire mipsCtrlPkg::aluOpT aluOp,
	input  wire mipsCtrlPkg::aluBSelT aluBSel,
	input  wire mipsCtrlPkg::extendSignT extendSign,
	output mipsIsaPkg::wordT aluResult,
	output logic zero
);

	localparam int extBits = mipsIsaPkg::dataWidth - mipsIsaPkg::immWidth;
	localparam int shamtPad = mipsIsaPkg::dataWidth - mipsIsaPkg::regAddrWidth;

	logic [mipsIsaPkg::immWidth-1:0] imm;
	logic [mipsIsaPkg::regAddrWidth-1:0] shamt;
	logic immTop;
	mipsIsaPkg::wordT extImm;
	mipsIsaPkg::wordT operandB;

	assign imm = instr[mipsIsaPkg::immWidth-1:0];
	assign shamt = instr[mipsIsaPkg::shamtLsb +: mipsIsaPkg::regAddrWidth];
	assign immTop = (extendSign == mipsCtrlPkg::extSign) && imm[mipsIsaPkg::immWidth-1];
	assign extImm = {{extBits{immTop}}, imm};

	always_comb begin
		case (aluBSel)
			mipsCtrlPkg::bSelImm: operandB = extImm;
			mipsCtrlPkg::bSelShamt: operandB = {{shamtPad{1'b0}}, shamt};
			default: operandB = readData2;
		endcase
	end

	always_comb begin
		case (aluOp)
			mipsCtrlPkg::aluSub: aluResult = readData1 - operandB;
			mipsCtrlPkg::aluAnd: aluResult = readData1 & operandB;
			mipsCtrlPkg::aluOr: aluResult = readData1 | operandB;
			mipsCtrlPkg::aluXor: aluResult = readData1 ^ operandB;
			mipsCtrlPkg::aluNor: aluResult = ~(readData1 | operandB);
			mipsCtrlPkg::aluSlt: begin
				aluResult = {{(mipsIsaPkg::dataWidth-1){1'b0}},
					$signed(readData1) < $signed(operandB)};
			end
			// Shifts move rt by shamt
			mipsCtrlPkg::aluSll: begin
				aluResult = readData2 << operandB[mipsIsaPkg::regAddrWidth-1:0];
			end
			mipsCtrlPkg::aluSrl: begin
				aluResult = readData2 >> operandB[mipsIsaPkg::regAddrWidth-1:0];
			end
			mipsCtrlPkg::aluLui: aluResult = operandB << mipsIsaPkg::immWidth;
			default: aluResult = readData1 + operandB; // ADD, loads and stores
		endcase
	end

	assign zero = (aluResult == '0);

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
	parameter mipsIsaPkg::wordT resetVector = '0
) (
	input  wire logic Clk,
	input  wire logic rstN,
	input  wire mipsCtrlPkg::branchKindT branchKind,
	input  wire mipsCtrlPkg::jumpKindT jumpKind,
	input  wire logic zero,
	input  wire logic [mipsIsaPkg::immWidth-1:0] immediate,
	input  wire logic [mipsIsaPkg::targetWidth-1:0] jumpTarget,
	input  wire mipsIsaPkg::wordT jumpReg,
	output mipsIsaPkg::wordT pc,
	output mipsIsaPkg::wordT pcPlus4
);

	localparam int extBits = mipsIsaPkg::dataWidth - mipsIsaPkg::immWidth - 2;
	localparam int topBits = mipsIsaPkg::dataWidth - mipsIsaPkg::targetWidth - 2;

	logic branchTaken;
	mipsIsaPkg::wordT branchAddr;
	mipsIsaPkg::wordT jumpAddr;
	mipsIsaPkg::wordT nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign branchAddr = pcPlus4 + {{extBits{immediate[mipsIsaPkg::immWidth-1]}}, immediate, 2'b00};
	assign jumpAddr = {pcPlus4[mipsIsaPkg::dataWidth-1 -: topBits], jumpTarget, 2'b00};

	// BEQ and BNE both compare through the ALU subtract
	assign branchTaken = (branchKind == mipsCtrlPkg::branchEq && zero) ||
		(branchKind == mipsCtrlPkg::branchNe && !zero);

	always_comb begin
		case (jumpKind)
			mipsCtrlPkg::jumpAbsolute: nextPc = jumpAddr;
			mipsCtrlPkg::jumpRegister: nextPc = jumpReg; // JR
			default: nextPc = branchTaken ? branchAddr : pcPlus4;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc <= resetVector;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryStage #(
	parameter int dataMemWords = 64
) (
	input  wire logic Clk,
	input  wire mipsIsaPkg::wordT aluResult,
	input  wire mipsIsaPkg::wordT storeData,
	input  wire logic memWrite,
	input  wire mipsCtrlPkg::wbSelT wbSel,
	input  wire mipsIsaPkg::wordT pcPlus4,
	output mipsIsaPkg::wordT wbData
);

	localparam int addrBits = (dataMemWords > 1) ? $clog2(dataMemWords) : 1;

	mipsIsaPkg::wordT mem [dataMemWords];
	logic [addrBits-1:0] wordAddr;
	mipsIsaPkg::wordT readData;

	assign wordAddr = aluResult[addrBits+1:2]; // Byte offset dropped
	assign readData = mem[wordAddr];

	always_ff @(posedge Clk) begin
		if (memWrite) begin
			mem[wordAddr] <= storeData;
		end
	end

	always_comb begin
		case (wbSel)
			mipsCtrlPkg::wbMem: wbData = readData;
			mipsCtrlPkg::wbLink: wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
	parameter mipsIsaPkg::wordT resetVector = '0,
	parameter int dataMemWords = 64
) (
	input  wire logic Clk,
	input  wire logic rstN,
	input  wire mipsIsaPkg::wordT instr,
	output mipsIsaPkg::wordT pc,
	output logic wbEn,
	output mipsIsaPkg::regAddrT wbAddr,
	output mipsIsaPkg::wordT wbData
);

	mipsCtrlPkg::aluOpT aluOp;
	mipsCtrlPkg::aluBSelT aluBSel;
	mipsCtrlPkg::extendSignT extendSign;
	mipsCtrlPkg::branchKindT branchKind;
	mipsCtrlPkg::jumpKindT jumpKind;
	mipsCtrlPkg::wbSelT wbSel;
	logic memWrite;
	logic zero;
	mipsIsaPkg::wordT readData1;
	mipsIsaPkg::wordT readData2;
	mipsIsaPkg::wordT aluResult;
	mipsIsaPkg::wordT pcPlus4;

	fetchUnit #(
		.resetVector(resetVector)
	) fetchUnit_inst (
		.Clk(Clk),
		.rstN(rstN),
		.branchKind(branchKind),
		.jumpKind(jumpKind),
		.zero(zero),
		.immediate(instr[mipsIsaPkg::immWidth-1:0]),
		.jumpTarget(instr[mipsIsaPkg::targetWidth-1:0]),
		.jumpReg(readData1),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	controlDecoder controlDecoder_inst (
		.instr(instr),
		.aluOp(aluOp),
		.aluBSel(aluBSel),
		.extendSign(extendSign),
		.branchKind(branchKind),
		.jumpKind(jumpKind),
		.wbSel(wbSel),
		.memWrite(memWrite),
		.regWrite(wbEn),
		.writeAddr(wbAddr)
	);

	registerFile registerFile_inst (
		.Clk(Clk),
		.rstN(rstN),
		.readAddr1(instr[mipsIsaPkg::rsLsb +: mipsIsaPkg::regAddrWidth]),
		.readAddr2(instr[mipsIsaPkg::rtLsb +: mipsIsaPkg::regAddrWidth]),
		.writeAddr(wbAddr),
		.writeData(wbData),
		.writeEn(wbEn),
		.readData1(readData1),
		.readData2(readData2)
	);

	executeUnit executeUnit_inst (
		.instr(instr),
		.readData1(readData1),
		.readData2(readData2),
		.aluOp(aluOp),
		.aluBSel(aluBSel),
		.extendSign(extendSign),
		.aluResult(aluResult),
		.zero(zero)
	);

	memoryStage #(
		.dataMemWords(dataMemWords)
	) memoryStage_inst (
		.Clk(Clk),
		.aluResult(aluResult),
		.storeData(readData2),
		.memWrite(memWrite),
		.wbSel(wbSel),
		.pcPlus4(pcPlus4),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// ==== hdl/mipsCtrlPkg.sv ====
`default_nettype none

package mipsCtrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSll,
		aluSrl,
		aluLui
	} aluOpT;

	typedef enum logic [1:0] {
		bSelRt,
		bSelImm,
		bSelShamt
	} aluBSelT;

	typedef enum logic [1:0] {
		branchNone,
		branchEq,
		branchNe
	} branchKindT;

	typedef enum logic [1:0] {
		jumpNone,
		jumpAbsolute, // 26-bit target field
		jumpRegister  // Address taken from rs
	} jumpKindT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSelT;

	typedef enum logic {
		extZero,
		extSign
	} extendSignT;

endpackage

`default_nettype wire

// ==== hdl/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// Instruction field positions and widths
	localparam int opLsb = 26;
	localparam int opcodeWidth = 6;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int shamtLsb = 6;
	localparam int functWidth = 6;
	localparam int immWidth = 16;
	localparam int targetWidth = 26;

	localparam logic [opcodeWidth-1:0] opSpecial = 6'd0;
	localparam logic [opcodeWidth-1:0] opJ = 6'd2;
	localparam logic [opcodeWidth-1:0] opJal = 6'd3;
	localparam logic [opcodeWidth-1:0] opBeq = 6'd4;
	localparam logic [opcodeWidth-1:0] opBne = 6'd5;
	localparam logic [opcodeWidth-1:0] opAddi = 6'd8;
	localparam logic [opcodeWidth-1:0] opAddiu = 6'd9;
	localparam logic [opcodeWidth-1:0] opSlti = 6'd10;
	localparam logic [opcodeWidth-1:0] opAndi = 6'd12;
	localparam logic [opcodeWidth-1:0] opOri = 6'd13;
	localparam logic [opcodeWidth-1:0] opXori = 6'd14;
	localparam logic [opcodeWidth-1:0] opLui = 6'd15;
	localparam logic [opcodeWidth-1:0] opLw = 6'd35;
	localparam logic [opcodeWidth-1:0] opSw = 6'd43;

	localparam logic [functWidth-1:0] fnSll = 6'd0;
	localparam logic [functWidth-1:0] fnSrl = 6'd2;
	localparam logic [functWidth-1:0] fnJr = 6'd8;
	localparam logic [functWidth-1:0] fnAdd = 6'd32;
	localparam logic [functWidth-1:0] fnAddu = 6'd33;
	localparam logic [functWidth-1:0] fnSub = 6'd34;
	localparam logic [functWidth-1:0] fnSubu = 6'd35;
	localparam logic [functWidth-1:0] fnAnd = 6'd36;
	localparam logic [functWidth-1:0] fnOr = 6'd37;
	localparam logic [functWidth-1:0] fnXor = 6'd38;
	localparam logic [functWidth-1:0] fnNor = 6'd39;
	localparam logic [functWidth-1:0] fnSlt = 6'd42;

	localparam regAddrT linkReg = 5'd31; // JAL destination

endpackage

`default_nettype wire

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input  wire logic Clk,
	input  wire logic rstN,
	input  wire mipsIsaPkg::regAddrT readAddr1,
	input  wire mipsIsaPkg::regAddrT readAddr2,
	input  wire mipsIsaPkg::regAddrT writeAddr,
	input  wire mipsIsaPkg::wordT writeData,
	input  wire logic writeEn,
	output mipsIsaPkg::wordT readData1,
	output mipsIsaPkg::wordT readData2
);

	localparam int numRegs = 2 ** mipsIsaPkg::regAddrWidth;

	mipsIsaPkg::wordT regs [numRegs];

	// r0 is hardwired to zero
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// ==== mipsCore.f ====
hdl/mipsIsaPkg.sv
hdl/mipsCtrlPkg.sv
hdl/fetchUnit.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/executeUnit.sv
hdl/memoryStage.sv
hdl/mipsCore.sv
testbench/mipsCoreChecker.sv
testbench/mipsCore_asserts.sv
testbench/mipsCoreTb.sv

// ==== testbench/mipsCoreChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreChecker (
	input  wire logic Clk,
	input  wire logic checkEn,
	input  wire mipsIsaPkg::wordT expPc,
	input  wire logic expWbEn,
	input  wire mipsIsaPkg::regAddrT expWbAddr,
	input  wire mipsIsaPkg::wordT expWbData,
	input  wire mipsIsaPkg::wordT pc,
	input  wire logic wbEn,
	input  wire mipsIsaPkg::regAddrT wbAddr,
	input  wire mipsIsaPkg::wordT wbData,
	output int errorCount,
	output int checkCount
);

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	// Outputs are settled by mid-cycle
	always @(negedge Clk) begin
		if (checkEn) begin
			checkCount++;
			if (pc !== expPc) begin
				errorCount++;
				$display("Error at %0t ns: pc is %h, expected %h", $time, pc, expPc);
			end
			if (wbEn !== expWbEn) begin
				errorCount++;
				$display("Error at %0t ns: wbEn is %b, expected %b at pc %h",
					$time, wbEn, expWbEn, expPc);
			end else if (expWbEn && (wbAddr !== expWbAddr || wbData !== expWbData)) begin
				errorCount++;
				$display("Error at %0t ns: write r%0d = %h, expected r%0d = %h at pc %h",
					$time, wbAddr, wbData, expWbAddr, expWbData, expPc);
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/mipsCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;

	localparam int resetCycles = 2;

	typedef struct packed {
		mipsIsaPkg::wordT instr;
		mipsIsaPkg::wordT pc;
		logic wbEn;
		mipsIsaPkg::regAddrT wbAddr;
		mipsIsaPkg::wordT wbData;
	} stepT;

	logic Clk;
	logic rstN;
	mipsIsaPkg::wordT instr;
	mipsIsaPkg::wordT pc;
	logic wbEn;
	mipsIsaPkg::regAddrT wbAddr;
	mipsIsaPkg::wordT wbData;

	logic checkEn;
	mipsIsaPkg::wordT expPc;
	logic expWbEn;
	mipsIsaPkg::regAddrT expWbAddr;
	mipsIsaPkg::wordT expWbData;
	int errorCount;
	int checkCount;
	int assertFails;
	int cycleCount;
	stepT steps [$];

	mipsCore #(
		.resetVector(32'h0000_0000),
		.dataMemWords(64)
	) mipsCore_inst (
		.Clk(Clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	mipsCoreChecker checker_inst (
		.Clk(Clk),
		.checkEn(checkEn),
		.expPc(expPc),
		.expWbEn(expWbEn),
		.expWbAddr(expWbAddr),
		.expWbData(expWbData),
		.pc(pc),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	always #10 Clk = ~Clk;

	function automatic mipsIsaPkg::wordT rFormat(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {mipsIsaPkg::opSpecial, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mipsIsaPkg::wordT immFormat(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsIsaPkg::wordT jumpFormat(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic expectStep(input mipsIsaPkg::wordT word, input mipsIsaPkg::wordT stepPc,
		input logic en, input mipsIsaPkg::regAddrT addr, input mipsIsaPkg::wordT data);
		steps.push_back('{word, stepPc, en, addr, data});
	endtask

	// Free-running guard against a stuck run
	always @(posedge Clk) begin
		cycleCount++;
		if (cycleCount > steps.size() + resetCycles + 10) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleCount - 1);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		Clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		checkEn = 1'b0;
		expPc = '0;
		expWbEn = 1'b0;
		expWbAddr = '0;
		expWbData = '0;
		cycleCount = 0;

		// Each row holds instruction, pc, wbEn, wbAddr and wbData
		expectStep(32'h0000_0000, 32'h00, 1'b1, 5'd0, 32'h0000_0000); // SLL r0 writes r0
		expectStep(immFormat(mipsIsaPkg::opAddi, 0, 1, 16'd5), 32'h04, 1'b1, 5'd1, 32'd5);
		expectStep(immFormat(mipsIsaPkg::opAddi, 0, 2, 16'hFFFD), 32'h08, 1'b1, 5'd2, 32'hFFFF_FFFD);
		expectStep(immFormat(mipsIsaPkg::opOri, 0, 3, 16'h8001), 32'h0C, 1'b1, 5'd3, 32'h0000_8001);
		expectStep(immFormat(mipsIsaPkg::opXori, 3, 4, 16'h00FF), 32'h10, 1'b1, 5'd4, 32'h0000_80FE);
		expectStep(immFormat(mipsIsaPkg::opAndi, 2, 5, 16'hF0F0), 32'h14, 1'b1, 5'd5, 32'h0000_F0F0);
		expectStep(immFormat(mipsIsaPkg::opLui, 0, 6, 16'h1234), 32'h18, 1'b1, 5'd6, 32'h1234_0000);
		expectStep(immFormat(mipsIsaPkg::opSlti, 2, 7, 16'hFFFF), 32'h1C, 1'b1, 5'd7, 32'd1);
		expectStep(immFormat(mipsIsaPkg::opSlti, 1, 8, 16'd4), 32'h20, 1'b1, 5'd8, 32'd0);
		expectStep(rFormat(mipsIsaPkg::fnAdd, 1, 2, 9, 0), 32'h24, 1'b1, 5'd9, 32'd2);
		expectStep(rFormat(mipsIsaPkg::fnSub, 1, 2, 10, 0), 32'h28, 1'b1, 5'd10, 32'd8);
		expectStep(rFormat(mipsIsaPkg::fnAnd, 3, 4, 11, 0), 32'h2C, 1'b1, 5'd11, 32'h0000_8000);
		expectStep(rFormat(mipsIsaPkg::fnOr, 1, 6, 12, 0), 32'h30, 1'b1, 5'd12, 32'h1234_0005);
		expectStep(rFormat(mipsIsaPkg::fnXor, 3, 4, 13, 0), 32'h34, 1'b1, 5'd13, 32'h0000_00FF);
		expectStep(rFormat(mipsIsaPkg::fnNor, 1, 0, 14, 0), 32'h38, 1'b1, 5'd14, 32'hFFFF_FFFA);
		expectStep(rFormat(mipsIsaPkg::fnSlt, 2, 1, 15, 0), 32'h3C, 1'b1, 5'd15, 32'd1);
		expectStep(rFormat(mipsIsaPkg::fnSll, 0, 1, 16, 4), 32'h40, 1'b1, 5'd16, 32'h0000_0050);
		expectStep(rFormat(mipsIsaPkg::fnSrl, 0, 2, 17, 28), 32'h44, 1'b1, 5'd17, 32'h0000_000F);
		expectStep(immFormat(mipsIsaPkg::opSw, 0, 6, 16'd12), 32'h48, 1'b0, 5'd0, 32'h0);
		expectStep(immFormat(mipsIsaPkg::opLw, 1, 18, 16'd7), 32'h4C, 1'b1, 5'd18, 32'h1234_0000);
		expectStep(immFormat(mipsIsaPkg::opBeq, 1, 1, 16'd2), 32'h50, 1'b0, 5'd0, 32'h0); // Taken
		expectStep(immFormat(mipsIsaPkg::opBeq, 1, 2, 16'd5), 32'h5C, 1'b0, 5'd0, 32'h0);
		expectStep(immFormat(mipsIsaPkg::opBne, 1, 2, 16'd1), 32'h60, 1'b0, 5'd0, 32'h0); // Taken
		expectStep(immFormat(mipsIsaPkg::opBne, 9, 9, 16'hFFF6), 32'h68, 1'b0, 5'd0, 32'h0);
		expectStep(jumpFormat(mipsIsaPkg::opJ, 26'h20), 32'h6C, 1'b0, 5'd0, 32'h0);
		expectStep(jumpFormat(mipsIsaPkg::opJal, 26'h40), 32'h80, 1'b1, 5'd31, 32'h84);
		expectStep(rFormat(mipsIsaPkg::fnJr, 31, 0, 0, 0), 32'h100, 1'b0, 5'd0, 32'h0);
		expectStep(rFormat(mipsIsaPkg::fnAdd, 31, 0, 20, 0), 32'h84, 1'b1, 5'd20, 32'h84);
		// Nonzero write to r0, later read back through rs
		expectStep(immFormat(mipsIsaPkg::opAddiu, 0, 0, 16'd7), 32'h88, 1'b1, 5'd0, 32'd7);
		expectStep(rFormat(mipsIsaPkg::fnAddu, 0, 1, 21, 0), 32'h8C, 1'b1, 5'd21, 32'd5);

		repeat (resetCycles) @(posedge Clk);
		#2;
		rstN = 1'b1;
		foreach (steps[i]) begin
			instr = steps[i].instr;
			expPc = steps[i].pc;
			expWbEn = steps[i].wbEn;
			expWbAddr = steps[i].wbAddr;
			expWbData = steps[i].wbData;
			checkEn = 1'b1;
			@(posedge Clk);
			#2;
		end
		checkEn = 1'b0;
		instr = '0;

		assertFails = mipsCore_inst.mipsCoreAsserts_inst.failCount;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0 && checkCount == steps.size()) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/mipsCore_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreAsserts #(
	parameter mipsIsaPkg::wordT resetVector = '0
) (
	input  wire logic Clk,
	input  wire logic rstN,
	input  wire mipsIsaPkg::wordT pc,
	input  wire logic wbEn,
	input  wire mipsIsaPkg::wordT wbData
);

	int failCount = 0;

	pcAligned: assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else begin
			failCount++;
			$error("pc %h is not word aligned", pc);
		end

	resetLoadsVector: assert property (@(posedge Clk) !rstN |=> pc == resetVector)
		else begin
			failCount++;
			$error("pc %h does not hold the reset vector after reset", pc);
		end

	// Register write data must be resolved
	wbDataKnown: assert property (@(posedge Clk) disable iff (!rstN) wbEn |-> !$isunknown(wbData))
		else begin
			failCount++;
			$error("wbData is unknown during a register write");
		end

endmodule

bind mipsCore mipsCoreAsserts #(
	.resetVector(resetVector)
) mipsCoreAsserts_inst (
	.Clk(Clk),
	.rstN(rstN),
	.pc(pc),
	.wbEn(wbEn),
	.wbData(wbData)
);

`default_nettype wire
